/* Makefile */
SIM      = verilator
TOP      = spi_memory_tb
FILELIST = spi_memory.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --timescale 1ns/1ps

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* bench/spi_memory_tb.sv */
// ######################################
// Mode 0 master with a 10-cycle half period.
// Stops at the first mismatch.
// ######################################
`timescale 1ns/1ps
`include "spi_memory_consts.svh"

module spi_memory_tb
	import spi_memory_pkg::*;
();

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 2;   // inputs change this long after posedge sclk.
	localparam int HALF         = 10;  // spi_clk half period in sclk cycles.
	localparam int NUM_RANDOM   = 300;
	localparam int NUM_ABORTS   = 24;
	localparam int NUM_TRANS    = `SPI_MEM_DEPTH + 2 + NUM_RANDOM + 2 * NUM_ABORTS;
	localparam int TRANS_CYCLES = 36 * HALF; // select, 16 bits, deselect gap.
	localparam int WATCHDOG_NS  = NUM_TRANS * TRANS_CYCLES * CLK_PERIOD * 2;
	localparam logic [31:0] SEED = 32'h05d6_05fa;

	logic sclk;
	logic rst_n;
	logic spi_clk;
	logic cs_n;
	logic mosi;
	logic miso;
	logic miso_oe;

	byte_t model [`SPI_MEM_DEPTH]; // expected memory contents.

	spi_memory uut (
		.sclk    (sclk),
		.rst_n   (rst_n),
		.spi_clk (spi_clk),
		.cs_n    (cs_n),
		.mosi    (mosi),
		.miso    (miso),
		.miso_oe (miso_oe)
	);

	initial begin
		sclk = 1'b0;
		forever #(CLK_PERIOD / 2) sclk = ~sclk;
	end

	// run length bound, twice the longest expected run
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the test sequence did not finish at %0t", $time);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sclk);
		#(DRIVE_DELAY);
	endtask

	task automatic check_byte(input byte_t got, input byte_t expected, input addr_t addr);
		if (got !== expected) begin
			$display("Error at %0t: read of address 0x%02h returned 0x%02h, expected 0x%02h",
				$time, addr, got, expected);
			$display("sim failed");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic check_oe(input logic got, input logic expected, input string phase);
		if (got !== expected) begin
			$display("Error at %0t: miso_oe is %b during %s, expected %b",
				$time, got, phase, expected);
			$display("sim failed");
			$fatal(1, "miso_oe mismatch");
		end
	endtask

	// clocks nbits bits of tx out, MSB first, and samples miso before each rise
	task automatic clock_bits(input byte_t tx, input int nbits, input logic oe_exp,
			input string phase, output byte_t rx);
		rx = '0;
		for (int i = 0; i < nbits; i++) begin
			mosi = tx[7 - i]; // data changes while spi_clk is low.
			wait_cycles(HALF);
			rx[7 - i] = miso;
			check_oe(miso_oe, oe_exp, phase);
			spi_clk = 1'b1;
			wait_cycles(HALF);
			spi_clk = 1'b0;
		end
	endtask

	task automatic deselect();
		wait_cycles(HALF);
		cs_n = 1'b1;
		mosi = 1'b0;
		wait_cycles(2 * HALF); // gap long enough for the FSM to settle in idle.
		check_oe(miso_oe, 1'b0, "deselect");
	endtask

	task automatic write_byte(input addr_t addr, input byte_t data);
		byte_t rx;
		cs_n = 1'b0;
		clock_bits({addr, 1'b0}, 8, 1'b0, "write command", rx);
		clock_bits(data, 8, 1'b0, "write data", rx);
		deselect();
		model[addr] = data;
	endtask

	task automatic read_byte(input addr_t addr, output byte_t data);
		byte_t rx;
		cs_n = 1'b0;
		clock_bits({addr, 1'b1}, 8, 1'b0, "read command", rx);
		clock_bits(8'h00, 8, 1'b1, "read data", data);
		deselect();
	endtask

	// write cut short by cs_n, the model keeps its old value
	task automatic abort_write(input addr_t addr, input byte_t data, input int nbits);
		byte_t rx;
		cs_n = 1'b0;
		clock_bits({addr, 1'b0}, 8, 1'b0, "aborted command", rx);
		clock_bits(data, nbits, 1'b0, "aborted data", rx);
		deselect();
	endtask

	initial begin
		logic [31:0] rnd;
		addr_t       addr;
		byte_t       data;
		byte_t       rx;
		int          nbits;

		rnd = $urandom(SEED); // seeds the generator for the whole run.
		rst_n   = 1'b0;
		spi_clk = 1'b0;
		cs_n    = 1'b1;
		mosi    = 1'b0;
		for (int a = 0; a < `SPI_MEM_DEPTH; a++) begin
			model[a] = '0;
		end

		wait_cycles(5);
		rst_n = 1'b1;
		wait_cycles(2 * HALF); // let the synchronisers see cs_n high.
		check_oe(miso_oe, 1'b0, "reset");

		// every location reads zero after reset
		for (int a = 0; a < `SPI_MEM_DEPTH; a++) begin
			addr = addr_t'(a);
			read_byte(addr, rx);
			check_byte(rx, 8'h00, addr);
		end

		// write then read back the same address
		addr = addr_t'($urandom);
		data = byte_t'($urandom);
		write_byte(addr, data);
		read_byte(addr, rx);
		check_byte(rx, data, addr);

		for (int n = 0; n < NUM_RANDOM; n++) begin
			rnd  = $urandom;
			addr = addr_t'($urandom);
			data = byte_t'($urandom);
			if (rnd[0]) begin
				write_byte(addr, data);
			end else begin
				read_byte(addr, rx);
				check_byte(rx, model[addr], addr);
			end
		end

		// aborted writes, each followed by a read of the same address
		for (int n = 0; n < NUM_ABORTS; n++) begin
			addr  = addr_t'($urandom);
			data  = ~model[addr]; // differs from the stored byte in every bit.
			nbits = $urandom_range(7, 0);
			abort_write(addr, data, nbits);
			read_byte(addr, rx);
			check_byte(rx, model[addr], addr);
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* spi_memory.f */
+incdir+verilog
verilog/spi_memory_pkg.sv
verilog/input_conditioner.sv
verilog/shift_register.sv
verilog/spi_fsm.sv
verilog/data_memory.sv
verilog/spi_memory.sv
bench/spi_memory_tb.sv

/* verilog/data_memory.sv */
// ######################################
// Read data lags the address latch by one cycle.
// All bytes clear on reset.
// ######################################
`timescale 1ns/1ps
`include "spi_memory_consts.svh"

module data_memory
	import spi_memory_pkg::*;
(
	input  logic  sclk,
	input  logic  rst_n,
	input  logic  addr_we,
	input  addr_t addr_in,
	input  logic  dm_we,
	input  byte_t data_in,
	output byte_t data_out
);

	addr_t addr_q;
	byte_t mem [`SPI_MEM_DEPTH];
	byte_t read_q;

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q <= '0;
			read_q <= '0;
			for (int i = 0; i < `SPI_MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else begin
			if (addr_we) begin
				addr_q <= addr_in; // held for the rest of the transaction.
			end
			if (dm_we) begin
				mem[addr_q] <= data_in;
			end
			read_q <= mem[addr_q]; // old byte on a same-cycle write.
		end
	end

	assign data_out = read_q;

endmodule

/* verilog/input_conditioner.sv */
// ######################################
// Synchroniser only, no debounce. Edge pulses last one
// sclk cycle, about three cycles after the pin moves.
// ######################################
`timescale 1ns/1ps
`include "spi_memory_consts.svh"

module input_conditioner
	import spi_memory_pkg::*;
(
	input  logic sclk,
	input  logic rst_n,
	input  logic pin,
	output logic level,
	output logic rise,
	output logic fall
);

	logic [`SPI_SYNC_STAGES-1:0] sync_q; // metastability chain.
	logic                        hist_q; // previous synchronised sample.

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
			hist_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[`SPI_SYNC_STAGES-2:0], pin}; // oldest sample at the top.
			hist_q <= sync_q[`SPI_SYNC_STAGES-1];
		end
	end

	assign level = sync_q[`SPI_SYNC_STAGES-1];

	// compare the two newest samples
	assign rise = level & ~hist_q;
	assign fall = ~level & hist_q;

endmodule

/* verilog/shift_register.sv */
// ######################################
// MSB first in both directions. Load wins over shift;
// shift_en and out_en never arrive in the same cycle.
// ######################################
`timescale 1ns/1ps
`include "spi_memory_consts.svh"

module shift_register
	import spi_memory_pkg::*;
(
	input  logic  sclk,
	input  logic  rst_n,
	input  logic  shift_en,
	input  logic  serial_in,
	input  logic  load,
	input  byte_t load_value,
	input  logic  out_en,
	output byte_t parallel_out,
	output logic  serial_out
);

	byte_t shift_q;
	logic  out_q;

	// byte register shifting toward the MSB
	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			shift_q <= '0;
		end else if (load) begin
			shift_q <= load_value; // read byte from memory.
		end else if (shift_en) begin
			shift_q <= {shift_q[`SPI_DATA_W-2:0], serial_in}; // new bit at the low end.
		end
	end

	// miso bit, updated on the falling spi_clk pulse so it is
	// stable across the next rising edge.
	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			out_q <= 1'b0;
		end else if (out_en) begin
			out_q <= shift_q[`SPI_DATA_W-1]; // top bit leaves first.
		end
	end

	assign parallel_out = shift_q;
	assign serial_out   = out_q;

endmodule

/* verilog/spi_fsm.sv */
// ######################################
// Mode 0 only, one byte per transaction. cs_n high aborts
// from any state; an aborted write never raises dm_we.
// ######################################
`timescale 1ns/1ps

module spi_fsm
	import spi_memory_pkg::*;
(
	input  logic  sclk,
	input  logic  rst_n,
	input  logic  cs_n,
	input  logic  clk_rise,
	input  byte_t shift_value,
	output logic  addr_we,
	output logic  dm_we,
	output logic  sr_we,
	output logic  miso_buff
);

	spi_state_t state;
	bit_count_t count;     // rising spi_clk edges in this byte.
	logic       rw_bit;    // latched r/w bit, cleared once the read byte is loaded.
	logic       read_wait; // first read cycle, memory output not yet valid.

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			count     <= '0;
			rw_bit    <= 1'b0;
			read_wait <= 1'b0;
		end else if (cs_n) begin
			// deselect ends the transaction wherever it is
			state     <= st_idle;
			count     <= '0;
			rw_bit    <= 1'b0;
			read_wait <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					state <= st_command;
					count <= '0;
				end

				st_command: begin
					if (count == 4'd8) begin
						// address is latched this cycle.
						rw_bit    <= shift_value[0];
						read_wait <= shift_value[0];
						count     <= '0;
						state     <= shift_value[0] ? st_read : st_write;
					end else if (clk_rise) begin
						count <= count + 4'd1;
					end
				end

				st_write: begin
					if (count == 4'd8) begin
						state <= st_done; // byte is stored this cycle.
					end else if (clk_rise) begin
						count <= count + 4'd1;
					end
				end

				st_read: begin
					read_wait <= 1'b0;
					if (sr_we) begin
						rw_bit <= 1'b0; // load only once.
					end
					if (count == 4'd8) begin
						state <= st_done;
					end else if (clk_rise) begin
						count <= count + 4'd1;
					end
				end

				st_done: begin
					state <= st_idle;
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// enables, one cycle each
	assign addr_we = (state == st_command) && (count == 4'd8);
	assign dm_we   = (state == st_write) && (count == 4'd8);

	// one cycle after the address latch the registered read is valid.
	assign sr_we = (state == st_read) && rw_bit && !read_wait;

	assign miso_buff = (state == st_read); // drive miso for the whole read.

endmodule

/* verilog/spi_memory.sv */
// ######################################
// spi_clk half period must be at least 8 sclk cycles.
// miso is valid only while miso_oe is high.
// ######################################
`timescale 1ns/1ps
`include "spi_memory_consts.svh"

module spi_memory
	import spi_memory_pkg::*;
(
	input  logic sclk,
	input  logic rst_n,
	input  logic spi_clk,
	input  logic cs_n,
	input  logic mosi,
	output logic miso,
	output logic miso_oe
);

	logic  clk_rise;
	logic  clk_fall;
	logic  cs_n_sync;
	logic  mosi_sync;
	byte_t shift_value;
	byte_t read_data;
	logic  addr_we;
	logic  dm_we;
	logic  sr_we;

	// only the edges of spi_clk are needed
	input_conditioner spi_clk_cond (
		.sclk  (sclk),
		.rst_n (rst_n),
		.pin   (spi_clk),
		.level (),
		.rise  (clk_rise),
		.fall  (clk_fall)
	);

	input_conditioner cs_n_cond (
		.sclk  (sclk),
		.rst_n (rst_n),
		.pin   (cs_n),
		.level (cs_n_sync),
		.rise  (),
		.fall  ()
	);

	input_conditioner mosi_cond (
		.sclk  (sclk),
		.rst_n (rst_n),
		.pin   (mosi),
		.level (mosi_sync),
		.rise  (),
		.fall  ()
	);

	shift_register shifter (
		.sclk         (sclk),
		.rst_n        (rst_n),
		.shift_en     (clk_rise),
		.serial_in    (mosi_sync),
		.load         (sr_we),
		.load_value   (read_data),
		.out_en       (clk_fall),
		.parallel_out (shift_value),
		.serial_out   (miso)
	);

	spi_fsm control (
		.sclk        (sclk),
		.rst_n       (rst_n),
		.cs_n        (cs_n_sync),
		.clk_rise    (clk_rise),
		.shift_value (shift_value),
		.addr_we     (addr_we),
		.dm_we       (dm_we),
		.sr_we       (sr_we),
		.miso_buff   (miso_oe)
	);

	data_memory memory (
		.sclk     (sclk),
		.rst_n    (rst_n),
		.addr_we  (addr_we),
		.addr_in  (shift_value[`SPI_DATA_W-1:1]), // address sits above the r/w bit.
		.dm_we    (dm_we),
		.data_in  (shift_value),
		.data_out (read_data)
	);

endmodule

/* verilog/spi_memory_consts.svh */
// ######################################
// Fixed by the byte protocol: a 7-bit address plus a r/w bit
// fill exactly one command byte, so keep these consistent.
// ######################################
`ifndef SPI_MEMORY_CONSTS_SVH
`define SPI_MEMORY_CONSTS_SVH

// command byte is address then r/w bit.
`define SPI_ADDR_W 7

// one data byte per transaction.
`define SPI_DATA_W 8

// one location per address.
`define SPI_MEM_DEPTH 128

// flops ahead of the edge history flop.
`define SPI_SYNC_STAGES 2

`endif

/* verilog/spi_memory_pkg.sv */
// ######################################
// Types shared by the SPI memory blocks.
// Widths come from the consts header.
// ######################################
package spi_memory_pkg;

	`include "spi_memory_consts.svh"

	// memory address, top seven bits of the command byte.
	typedef logic [`SPI_ADDR_W-1:0] addr_t;

	// data byte, also holds the command while it shifts in.
	typedef logic [`SPI_DATA_W-1:0] byte_t;

	// bits taken in the current byte, 0 to 8.
	typedef logic [3:0] bit_count_t;

	// transaction states.
	typedef enum logic [2:0] {
		st_idle,
		st_command,
		st_write,
		st_read,
		st_done
	} spi_state_t;

endpackage
